/* verilog/rfStack_params.svh */
// size macros for the banked register file, included by the package and the RTL modules
`ifndef RFSTACK_PARAMS_SVH
`define RFSTACK_PARAMS_SVH

// width of one general purpose register
`define RF_DATA_WIDTH 32

// registers in each bank, x0 to x31
`define RF_NUM_REGS 32

// nested interrupt levels, one bank per level
// level 0 is the base (thread) level
`define RF_NUM_LEVELS 8

// byte address width of the APB slave port
// registers sit in the upper half of the map
`define RF_ADDR_WIDTH 8

`endif

/* verilog/rfStack_pkg.sv */
// shared types of the banked register file: widths, APB bus structs, write bundle, FSM state
`default_nettype none

package rfStack_pkg;

  `include "rfStack_params.svh"

  // widths that carry a meaning
  typedef logic [`RF_DATA_WIDTH-1:0]          dataT;      // one register value
  typedef logic [$clog2(`RF_NUM_REGS)-1:0]    regIndexT;  // register index
  typedef logic [$clog2(`RF_NUM_LEVELS)-1:0]  levelT;     // interrupt level
  typedef logic [`RF_ADDR_WIDTH-1:0]          apbAddrT;   // APB byte address

  // APB master to slave
  typedef struct packed {
    logic    psel;
    logic    penable;
    logic    pwrite;
    apbAddrT paddr;
    dataT    pwdata;
  } apbReqT;

  // APB slave to master
  typedef struct packed {
    dataT prdata;
    logic pready;
    logic pslverr;
  } apbRspT;

  // one register write, takes effect at the next edge
  typedef struct packed {
    logic     en;
    regIndexT addr;
    dataT     data;
  } rfWriteT;

  // level controller: LINKWRITE is the cycle after an entry
  typedef enum logic {
    IDLE,
    LINKWRITE
  } levelStateT;

endpackage

`default_nettype wire

/* verilog/rfStack.sv */
// banked register file with a shared stack pointer, used by regBankTop for APB and debug reads
`timescale 1ns/1ps
`default_nettype none

`include "rfStack_params.svh"

module rfStack (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire rfStack_pkg::rfWriteT wr,
  input  wire logic                 writeRaEn,
  input  wire rfStack_pkg::dataT    writeRaData,
  input  wire rfStack_pkg::levelT   level,
  input  wire rfStack_pkg::regIndexT readAddr1,
  input  wire rfStack_pkg::regIndexT readAddr2,
  output rfStack_pkg::dataT         readData1,
  output rfStack_pkg::dataT         readData2,
  output rfStack_pkg::dataT         readRa
);

  localparam rfStack_pkg::regIndexT raIndex = 1;  // link register
  localparam rfStack_pkg::regIndexT spIndex = 2;  // stack pointer, bank 0 only

  rfStack_pkg::dataT [`RF_NUM_LEVELS-1:0][`RF_NUM_REGS-1:0] regs;
  rfStack_pkg::levelT levelMinus1;

  // the interrupted level owns the bank just below the current one
  assign levelMinus1 = level - 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= '0;
    end else begin
      if (wr.en && wr.addr != '0) begin  // x0 is hardwired
        if (wr.addr == spIndex) begin
          regs[0][wr.addr] <= wr.data;  // sp shared by all levels
        end else begin
          regs[level][wr.addr] <= wr.data;
        end
      end
      if (writeRaEn) begin
        regs[levelMinus1][raIndex] <= writeRaData;  // return address into caller's ra
      end
    end
  end

  // one read port, same rules for both
  function automatic rfStack_pkg::dataT readPort(input rfStack_pkg::regIndexT addr);
    rfStack_pkg::dataT value;
    if (addr == '0) begin
      value = '0;
    end else if (wr.en && wr.addr == addr) begin
      value = wr.data;  // write-through
    end else if (addr == spIndex) begin
      value = regs[0][addr];
    end else begin
      value = regs[level][addr];
    end
    return value;
  endfunction

  always_comb begin
    readData1 = readPort(readAddr1);
    readData2 = readPort(readAddr2);
    readRa    = regs[level][raIndex];  // ra of the current bank, no write-through
  end

endmodule

`default_nettype wire

/* verilog/levelControl.sv */
// interrupt level counter for regBankTop, handles entry and exit and issues the link write
`timescale 1ns/1ps
`default_nettype none

`include "rfStack_params.svh"

module levelControl (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               entryReq,
  input  wire logic               exitReq,
  input  wire rfStack_pkg::dataT  retAddr,
  output rfStack_pkg::levelT      level,
  output rfStack_pkg::rfWriteT    raWr,
  output logic                    levelErr
);

  localparam rfStack_pkg::levelT topLevel = rfStack_pkg::levelT'(`RF_NUM_LEVELS - 1);

  rfStack_pkg::levelStateT state;
  rfStack_pkg::dataT       raHold;  // return address waiting for the link write
  logic atTop;
  logic atBottom;
  logic entryOk;
  logic exitOk;

  assign atTop    = (level == topLevel);
  assign atBottom = (level == '0);

  // overflow and underflow are refused in the same cycle
  assign levelErr = (entryReq && atTop) || (exitReq && atBottom);
  assign entryOk  = entryReq && !atTop;
  assign exitOk   = exitReq && !atBottom;

  always_ff @(posedge clk) begin
    if (reset) begin
      level <= '0;
      state <= rfStack_pkg::IDLE;
    end else begin
      if (entryOk) begin
        level <= level + 1'b1;
      end else if (exitOk) begin
        level <= level - 1'b1;
      end
      unique case (state)
        rfStack_pkg::IDLE: begin
          if (entryOk) state <= rfStack_pkg::LINKWRITE;
        end
        rfStack_pkg::LINKWRITE: begin
          state <= entryOk ? rfStack_pkg::LINKWRITE : rfStack_pkg::IDLE;
        end
        default: state <= rfStack_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (entryOk) raHold <= retAddr;
  end

  // level has already moved up, so rfStack writes bank level-1
  always_comb begin
    raWr.en   = (state == rfStack_pkg::LINKWRITE);
    raWr.addr = rfStack_pkg::regIndexT'(1);  // x1, fixed target
    raWr.data = raHold;
  end

endmodule

`default_nettype wire

/* verilog/apbRegPort.sv */
// APB slave of regBankTop, maps bus transfers to register accesses and level commands
`timescale 1ns/1ps
`default_nettype none

`include "rfStack_params.svh"

module apbRegPort (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire rfStack_pkg::apbReqT   apbReq,
  output rfStack_pkg::apbRspT        apbRsp,
  output rfStack_pkg::rfWriteT       rfWr,
  output rfStack_pkg::regIndexT      rdAddr,
  input  wire rfStack_pkg::dataT     rdData,
  input  wire rfStack_pkg::dataT     readRa,
  input  wire rfStack_pkg::levelT    level,
  output logic                       entryReq,
  output logic                       exitReq,
  output rfStack_pkg::dataT          retAddr,
  input  wire logic                  levelErr
);

  // word addresses of the command block
  localparam rfStack_pkg::apbAddrT addrLevel = 'h00;
  localparam rfStack_pkg::apbAddrT addrEntry = 'h04;
  localparam rfStack_pkg::apbAddrT addrExit  = 'h08;
  localparam rfStack_pkg::apbAddrT addrRa    = 'h0C;

  rfStack_pkg::apbAddrT addr;
  logic setupSeen;  // previous cycle was a setup phase
  logic accessPhase;
  logic access;
  logic isReg;
  logic isLevel;
  logic isEntry;
  logic isExit;
  logic isRa;
  logic decoded;
  logic roWrite;

  assign addr        = apbReq.paddr;
  assign accessPhase = apbReq.psel && apbReq.penable;

  // a held penable would otherwise repeat the command
  always_ff @(posedge clk) begin
    if (reset) begin
      setupSeen <= 1'b0;
    end else begin
      setupSeen <= apbReq.psel && !apbReq.penable;
    end
  end

  assign access = accessPhase && setupSeen;  // first access cycle only

  // upper half of the map holds x0..x31, word aligned
  assign isReg   = addr[`RF_ADDR_WIDTH-1] && (addr[1:0] == 2'b00);
  assign isLevel = (addr == addrLevel);
  assign isEntry = (addr == addrEntry);
  assign isExit  = (addr == addrExit);
  assign isRa    = (addr == addrRa);
  assign decoded = isReg || isLevel || isEntry || isExit || isRa;
  assign roWrite = apbReq.pwrite && (isLevel || isRa);

  // register path
  assign rdAddr = addr[6:2];
  always_comb begin
    rfWr.en   = access && apbReq.pwrite && isReg;
    rfWr.addr = addr[6:2];
    rfWr.data = apbReq.pwdata;
  end

  // level commands, one cycle pulses
  assign entryReq = access && apbReq.pwrite && isEntry;
  assign exitReq  = access && apbReq.pwrite && isExit;
  assign retAddr  = apbReq.pwdata;

  always_comb begin
    if (isReg) begin
      apbRsp.prdata = rdData;
    end else if (isLevel) begin
      apbRsp.prdata = rfStack_pkg::dataT'(level);  // zero extended
    end else if (isRa) begin
      apbRsp.prdata = readRa;
    end else begin
      apbRsp.prdata = '0;
    end
    apbRsp.pready  = accessPhase;  // no wait states
    apbRsp.pslverr = access && (!decoded || roWrite || levelErr);
  end

endmodule

`default_nettype wire

/* verilog/regBankTop.sv */
// top of the banked register file, APB slave plus a read-only debug port for the testbench
`timescale 1ns/1ps
`default_nettype none

module regBankTop (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire rfStack_pkg::apbReqT   apbReq,
  output rfStack_pkg::apbRspT        apbRsp,
  input  wire rfStack_pkg::regIndexT dbgAddr,
  output rfStack_pkg::dataT          dbgData
);

  rfStack_pkg::rfWriteT  rfWr;
  rfStack_pkg::rfWriteT  raWr;      // link write, addr not used
  rfStack_pkg::regIndexT rdAddr;
  rfStack_pkg::dataT     rdData;
  rfStack_pkg::dataT     readRa;
  rfStack_pkg::dataT     retAddr;
  rfStack_pkg::levelT    level;
  logic entryReq;
  logic exitReq;
  logic levelErr;

  apbRegPort port_i (
    .clk      (clk),
    .reset    (reset),
    .apbReq   (apbReq),
    .apbRsp   (apbRsp),
    .rfWr     (rfWr),
    .rdAddr   (rdAddr),
    .rdData   (rdData),
    .readRa   (readRa),
    .level    (level),
    .entryReq (entryReq),
    .exitReq  (exitReq),
    .retAddr  (retAddr),
    .levelErr (levelErr)
  );

  levelControl levelCtl_i (
    .clk      (clk),
    .reset    (reset),
    .entryReq (entryReq),
    .exitReq  (exitReq),
    .retAddr  (retAddr),
    .level    (level),
    .raWr     (raWr),
    .levelErr (levelErr)
  );

  // port 1 serves APB, port 2 the debug pair
  rfStack rf_i (
    .clk         (clk),
    .reset       (reset),
    .wr          (rfWr),
    .writeRaEn   (raWr.en),
    .writeRaData (raWr.data),
    .level       (level),
    .readAddr1   (rdAddr),
    .readAddr2   (dbgAddr),
    .readData1   (rdData),
    .readData2   (dbgData),
    .readRa      (readRa)
  );

endmodule

`default_nettype wire

/* bench/regBank_assertions.sv */
// concurrent checks on the APB handshake and the level controller that are bound into regBankTop
`timescale 1ns/1ps
`default_nettype none

module regBankAssertions (
  input wire logic                 clk,
  input wire logic                 reset,
  input wire rfStack_pkg::apbReqT  apbReq,
  input wire rfStack_pkg::apbRspT  apbRsp,
  input wire rfStack_pkg::levelT   level,
  input wire rfStack_pkg::rfWriteT raWr
);

  logic accessCycle;
  logic entryAccepted;  // entry command seen on the bus without pslverr

  assign accessCycle   = apbReq.psel && apbReq.penable;
  assign entryAccepted = accessCycle && apbReq.pwrite && (apbReq.paddr == 8'h04)
                         && !apbRsp.pslverr;

  // zero wait states and a known response in every access cycle
  accessReady: assert property (@(posedge clk) disable iff (reset)
    accessCycle |-> (apbRsp.pready && !$isunknown(apbRsp)))
    else $error("pready low or response unknown during an APB access cycle");

  // level is always a known value and moves by one step at most
  levelStep: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(level) && ((int'(level) - int'($past(level))) inside {-1, 0, 1}))
    else $error("level unknown or changed by more than one");

  // the link write follows an entry that the bus saw accepted
  linkAfterEntry: assert property (@(posedge clk) disable iff (reset)
    raWr.en |-> $past(entryAccepted))
    else $error("link write without an accepted entry one cycle before");

endmodule

bind regBankTop regBankAssertions assert_i (
  .clk    (clk),
  .reset  (reset),
  .apbReq (apbReq),
  .apbRsp (apbRsp),
  .level  (level),
  .raWr   (raWr)
);

`default_nettype wire

/* bench/regBankChecker.sv */
// testbench checker, models the banks and level of regBankTop and compares every access cycle
`timescale 1ns/1ps
`default_nettype none

module regBankChecker (
  input wire logic                  clk,
  input wire logic                  reset,
  input wire rfStack_pkg::apbReqT   apbReq,
  input wire rfStack_pkg::apbRspT   apbRsp,
  input wire rfStack_pkg::regIndexT dbgAddr,
  input wire rfStack_pkg::dataT     dbgData,
  input wire logic                  expErr,   // from the stimulus table
  input wire logic [7:0]            testId,
  input wire logic                  testEnd,
  output int                        errorCount,
  output int                        testsPassed,
  output int                        testsFailed
);

  rfStack_pkg::dataT  bank [8][32];  // reference banks, one per level
  rfStack_pkg::levelT level;
  int testErrors;

  // x0 is zero, x2 always lives in bank 0
  function automatic rfStack_pkg::dataT modelRead(input rfStack_pkg::regIndexT idx);
    rfStack_pkg::dataT value;
    if (idx == 5'd0) value = '0;
    else if (idx == 5'd2) value = bank[0][idx];
    else value = bank[level][idx];
    return value;
  endfunction

  task automatic modelWrite(input rfStack_pkg::regIndexT idx, input rfStack_pkg::dataT data);
    if (idx == 5'd2) bank[0][idx] = data;
    else if (idx != 5'd0) bank[level][idx] = data;
  endtask

  task automatic compare(input string name, input rfStack_pkg::dataT expected,
                         input rfStack_pkg::dataT actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected 0x%h, actual 0x%h (test %0d)", name, expected, actual, testId);
      errorCount++;
      testErrors++;
    end
  endtask

  task automatic checkAccess();
    rfStack_pkg::apbAddrT  a;
    rfStack_pkg::regIndexT idx;
    logic isReg;
    a = apbReq.paddr;
    idx = a[6:2];
    isReg = a[7] && (a[1:0] == 2'b00);  // 0x80..0xFC, word aligned
    compare("pslverr", rfStack_pkg::dataT'(expErr), rfStack_pkg::dataT'(apbRsp.pslverr));
    if (apbReq.pwrite) begin
      if (isReg) begin
        if (dbgAddr == idx) begin  // write-through on the debug port
          compare("dbgData", (idx == 5'd0) ? '0 : apbReq.pwdata, dbgData);
        end
        modelWrite(idx, apbReq.pwdata);
      end else if (a == 8'h04 && level != 3'd7) begin
        bank[level][1] = apbReq.pwdata;  // return address lands in the interrupted bank
        level++;
      end else if (a == 8'h08 && level != 3'd0) begin
        level--;
      end
    end else if (!expErr) begin
      if (isReg) compare("prdata", modelRead(idx), apbRsp.prdata);
      else if (a == 8'h00) compare("prdata", rfStack_pkg::dataT'(level), apbRsp.prdata);
      else if (a == 8'h0C) compare("prdata", bank[level][1], apbRsp.prdata);
    end
  endtask

  task automatic reportTest();
    if (testErrors == 0) begin
      $display("test %0d passed", testId);
      testsPassed++;
    end else begin
      $display("test %0d failed with %0d errors", testId, testErrors);
      testsFailed++;
    end
    testErrors = 0;
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (reset) begin
      foreach (bank[i, j]) bank[i][j] = '0;
      level = '0;
      testErrors = 0;
    end else begin
      if (apbReq.psel && apbReq.penable) checkAccess();
      if (testEnd) reportTest();
    end
  end

endmodule

`default_nettype wire

/* bench/regBankTb.sv */
// testbench top for regBankTop, applies the stimulus table over APB and prints the verdict
`timescale 1ns/1ps
`default_nettype none

module regBankTb;

  typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_ENTRY, OP_EXIT, OP_LEVEL, OP_RA} opT;

  typedef struct packed {
    opT                   op;
    rfStack_pkg::apbAddrT addr;    // register ops only
    rfStack_pkg::dataT    data;    // write data or return address
    logic                 expErr;  // pslverr expected
    logic [7:0]           testId;
  } stepT;

  logic                  clk = 1'b0;
  logic                  reset;
  rfStack_pkg::apbReqT   apbReq;
  rfStack_pkg::apbRspT   apbRsp;
  rfStack_pkg::regIndexT dbgAddr;
  rfStack_pkg::dataT     dbgData;
  logic                  expErr;
  logic [7:0]            testId;
  logic                  testEnd;
  int                    errorCount;
  int                    testsPassed;
  int                    testsFailed;
  stepT                  steps[$];
  integer                seed;
  int                    cycleCount = 0;
  int                    cycleLimit = 100000;

  always #4 clk = ~clk;

  regBankTop dut_i (
    .clk     (clk),
    .reset   (reset),
    .apbReq  (apbReq),
    .apbRsp  (apbRsp),
    .dbgAddr (dbgAddr),
    .dbgData (dbgData)
  );

  regBankChecker checker_i (
    .clk         (clk),
    .reset       (reset),
    .apbReq      (apbReq),
    .apbRsp      (apbRsp),
    .dbgAddr     (dbgAddr),
    .dbgData     (dbgData),
    .expErr      (expErr),
    .testId      (testId),
    .testEnd     (testEnd),
    .errorCount  (errorCount),
    .testsPassed (testsPassed),
    .testsFailed (testsFailed)
  );

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic addStep(input opT op, input int addr, input rfStack_pkg::dataT data,
                         input logic err, input int id);
    stepT s;
    s.op = op;
    s.addr = rfStack_pkg::apbAddrT'(addr);
    s.data = data;
    s.expErr = err;
    s.testId = 8'(id);
    steps.push_back(s);
  endtask

  task automatic buildTable();
    int i;
    addStep(OP_LEVEL, 0, 0, 1'b0, 1);  // reset state
    for (i = 0; i < 32; i++) addStep(OP_READ, 'h80 + 4 * i, 0, 1'b0, 1);
    addStep(OP_WRITE, 'h94, 32'h1111_0005, 1'b0, 2);  // x5 per level
    addStep(OP_ENTRY, 0, 32'h0000_1000, 1'b0, 2);
    addStep(OP_WRITE, 'h94, 32'h2222_0005, 1'b0, 2);
    addStep(OP_READ, 'h94, 0, 1'b0, 2);
    addStep(OP_EXIT, 0, 0, 1'b0, 2);
    addStep(OP_READ, 'h94, 0, 1'b0, 2);
    addStep(OP_WRITE, 'h80, 32'hdead_beef, 1'b0, 3);  // x0 and shared sp
    addStep(OP_READ, 'h80, 0, 1'b0, 3);
    for (i = 0; i < 3; i++) addStep(OP_ENTRY, 0, 32'h3000 + i, 1'b0, 3);
    addStep(OP_WRITE, 'h88, 32'h5a5a_0002, 1'b0, 3);
    for (i = 0; i < 3; i++) addStep(OP_EXIT, 0, 0, 1'b0, 3);
    addStep(OP_LEVEL, 0, 0, 1'b0, 3);
    addStep(OP_READ, 'h88, 0, 1'b0, 3);
    addStep(OP_ENTRY, 0, 32'h0000_0100, 1'b0, 4);  // nested entry, then exit
    addStep(OP_ENTRY, 0, 32'h0000_2468, 1'b0, 4);
    addStep(OP_LEVEL, 0, 0, 1'b0, 4);
    addStep(OP_EXIT, 0, 0, 1'b0, 4);
    addStep(OP_LEVEL, 0, 0, 1'b0, 4);
    addStep(OP_RA, 0, 0, 1'b0, 4);
    addStep(OP_READ, 'h84, 0, 1'b0, 4);
    addStep(OP_EXIT, 0, 0, 1'b0, 4);
    addStep(OP_EXIT, 0, 0, 1'b1, 5);  // underflow
    addStep(OP_LEVEL, 0, 0, 1'b0, 5);
    for (i = 0; i < 7; i++) addStep(OP_ENTRY, 0, 32'h5000 + i, 1'b0, 5);
    addStep(OP_ENTRY, 0, 32'h0000_5fff, 1'b1, 5);  // overflow
    addStep(OP_LEVEL, 0, 0, 1'b0, 5);
    for (i = 0; i < 7; i++) addStep(OP_EXIT, 0, 0, 1'b0, 5);
    addStep(OP_WRITE, 'h40, 32'h0000_0040, 1'b1, 5);  // unmapped
    addStep(OP_READ, 'h10, 0, 1'b1, 5);
    addStep(OP_WRITE, 'h00, 32'h0000_0003, 1'b1, 5);  // read-only level
    addStep(OP_WRITE, 'h82, 32'h0000_0082, 1'b1, 5);  // unaligned
    addStep(OP_LEVEL, 0, 0, 1'b0, 5);
    addStep(OP_WRITE, 'h9c, 32'hcafe_0007, 1'b0, 6);  // debug write-through
    addStep(OP_WRITE, 'h80, 32'h1234_5678, 1'b0, 6);
    addStep(OP_WRITE, 'hfc, 32'h0bad_f00d, 1'b0, 6);
    for (i = 8; i < 32; i++) addStep(OP_WRITE, 'h80 + 4 * i, $random(seed), 1'b0, 7);
    for (i = 8; i < 32; i++) addStep(OP_READ, 'h80 + 4 * i, 0, 1'b0, 7);
  endtask

  // one setup cycle, then the access cycle until pready
  task automatic applyStep(input stepT s);
    rfStack_pkg::apbReqT req;
    req = '0;
    req.psel = 1'b1;
    case (s.op)
      OP_WRITE: begin
        req.pwrite = 1'b1;
        req.paddr = s.addr;
        req.pwdata = s.data;
      end
      OP_READ: req.paddr = s.addr;
      OP_ENTRY: begin
        req.pwrite = 1'b1;
        req.paddr = 8'h04;
        req.pwdata = s.data;
      end
      OP_EXIT: begin
        req.pwrite = 1'b1;
        req.paddr = 8'h08;
      end
      OP_LEVEL: req.paddr = 8'h00;
      default: req.paddr = 8'h0c;
    endcase
    expErr = s.expErr;
    testId = s.testId;
    dbgAddr = req.paddr[6:2];
    apbReq = req;
    @(posedge clk);
    #1;
    req.penable = 1'b1;
    apbReq = req;
    @(posedge clk);
    while (!apbRsp.pready) @(posedge clk);
    #1;
    apbReq = '0;
  endtask

  task automatic endTest();
    testEnd = 1'b1;
    @(posedge clk);
    #1;
    testEnd = 1'b0;
  endtask

  initial begin
    int i;
    apbReq = '0;
    dbgAddr = '0;
    expErr = 1'b0;
    testId = '0;
    testEnd = 1'b0;
    reset = 1'b1;
    seed = 32'h63289b6b;
    buildTable();
    cycleLimit = steps.size() * 4 + 50;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    for (i = 0; i < steps.size(); i++) begin
      applyStep(steps[i]);
      if (i == steps.size() - 1 || steps[i + 1].testId != steps[i].testId) endTest();
    end
    $display("tests passed %0d, tests failed %0d, mismatches %0d",
             testsPassed, testsFailed, errorCount);
    if (testsFailed == 0 && errorCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+verilog
verilog/rfStack_pkg.sv
verilog/rfStack.sv
verilog/levelControl.sv
verilog/apbRegPort.sv
verilog/regBankTop.sv
bench/regBank_assertions.sv
bench/regBankChecker.sv
bench/regBankTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = regBankTb
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
